/* logic/oq_pkg.sv */
`default_nettype none

package oq_pkg;

    ////////////////////
    // queue sizing
    ////////////////////

    // words in the shared packet buffer
    localparam int buffer_depth      = 256;
    localparam int buffer_addr_width = 8;

    // almost full once free words drop to this level
    localparam int almost_full_level = 32;

    // pending packets held by the rank sorter
    localparam int sorter_depth      = 16;
    localparam int rank_width        = 16;

    ////////////////////
    // types
    ////////////////////

    // one word address in the buffer
    typedef logic [buffer_addr_width-1:0] buf_addr_t;

    // word count, one extra bit so a full buffer reads 256
    typedef logic [buffer_addr_width:0] buf_count_t;

    // scheduling rank, lower leaves first
    typedef logic [rank_width-1:0] rank_t;

    // one pending packet in the sorter
    typedef struct packed {
        rank_t     rank;
        buf_addr_t sop_addr;
    } sorter_entry_t;

endpackage

`default_nettype wire

/* logic/oq_stream_pkg.sv */
`default_nettype none

package oq_stream_pkg;

    ////////////////////
    // beat geometry
    ////////////////////

    // payload bits per beat
    localparam int beat_data_width = 64;

    // one keep bit per payload byte
    localparam int beat_keep_width = 8;

    typedef logic [beat_data_width-1:0] beat_data_t;
    typedef logic [beat_keep_width-1:0] beat_keep_t;

    // one stream beat as stored in the buffer and sent on egress
    typedef struct packed {
        beat_data_t data;
        beat_keep_t keep;
        logic       last;
    } stream_beat_t;

endpackage

`default_nettype wire

/* logic/pkt_buffer.sv */
`timescale 1ns/100ps
`default_nettype none

module pkt_buffer
(
    input  wire logic                        axis_aclk,
    input  wire logic                        axis_resetn,

    // ingress side
    input  wire logic                        wr_valid,
    input  wire oq_stream_pkg::stream_beat_t wr_beat,
    input  wire oq_pkg::rank_t               wr_rank,

    // read side, driven by the dequeue controller
    input  wire logic                        rd_en,
    input  wire oq_pkg::buf_addr_t           rd_addr,
    output oq_stream_pkg::stream_beat_t      rd_beat,
    output oq_pkg::buf_addr_t                rd_next,

    // completed packet towards the sorter
    output oq_pkg::sorter_entry_t            pkt_entry,
    output logic                             pkt_done,

    // occupancy
    output oq_pkg::buf_count_t               buffer_free,
    output oq_pkg::buf_count_t               buffer_used,
    output logic                             almost_full
);

    // word store and per-word next pointer
    oq_stream_pkg::stream_beat_t word_mem [oq_pkg::buffer_depth];
    oq_pkg::buf_addr_t           link_mem [oq_pkg::buffer_depth];

    // free list ends
    oq_pkg::buf_addr_t fl_head;
    oq_pkg::buf_addr_t fl_tail;
    logic              fl_drained;

    // packet being received
    logic              in_pkt;
    oq_pkg::buf_addr_t prev_addr;
    oq_pkg::buf_addr_t sop_addr;
    oq_pkg::rank_t     pkt_rank;

    // free list empty after this cycle's allocation
    // returned word then becomes the new head
    assign fl_drained = (buffer_free == '0) ||
                        ((buffer_free == oq_pkg::buf_count_t'(1)) && wr_valid);

    ////////////////////
    // link table, free list
    ////////////////////

    always_ff @(posedge axis_aclk)
    begin
        if (!axis_resetn)
        begin
            // free chain 0 -> 1 -> ... -> 255
            for (int i = 0; i < oq_pkg::buffer_depth; i++)
            begin
                link_mem[i] <= oq_pkg::buf_addr_t'(i + 1);
            end
            fl_head <= '0;
            fl_tail <= oq_pkg::buf_addr_t'(oq_pkg::buffer_depth - 1);
        end
        else
        begin
            if (wr_valid)
            begin
                // allocate head word
                fl_head <= link_mem[fl_head];
                // chain previous word of this packet
                if (in_pkt)
                begin
                    link_mem[prev_addr] <= fl_head;
                end
            end
            if (rd_en)
            begin
                // read word goes back on the tail
                fl_tail <= rd_addr;
                if (fl_drained)
                begin
                    fl_head <= rd_addr;
                end
                else
                begin
                    link_mem[fl_tail] <= rd_addr;
                end
            end
        end
    end

    ////////////////////
    // packet tracking
    ////////////////////

    always_ff @(posedge axis_aclk)
    begin
        if (!axis_resetn)
        begin
            in_pkt   <= 1'b0;
            pkt_done <= 1'b0;
        end
        else
        begin
            // entry goes out one cycle after the last beat
            pkt_done <= wr_valid && wr_beat.last;
            if (wr_valid)
            begin
                in_pkt <= !wr_beat.last;
            end
        end
    end

    // payload path
    always_ff @(posedge axis_aclk)
    begin
        if (wr_valid)
        begin
            word_mem[fl_head] <= wr_beat;
            prev_addr         <= fl_head;
            // first beat, latch sop and rank
            if (!in_pkt)
            begin
                sop_addr <= fl_head;
                pkt_rank <= wr_rank;
            end
            // single-beat packet takes sop and rank straight from this beat
            if (wr_beat.last)
            begin
                pkt_entry.rank     <= in_pkt ? pkt_rank : wr_rank;
                pkt_entry.sop_addr <= in_pkt ? sop_addr : fl_head;
            end
        end
        // read data and link, one cycle after rd_en
        if (rd_en)
        begin
            rd_beat <= word_mem[rd_addr];
            rd_next <= link_mem[rd_addr];
        end
    end

    ////////////////////
    // occupancy
    ////////////////////

    always_ff @(posedge axis_aclk)
    begin
        if (!axis_resetn)
        begin
            buffer_free <= oq_pkg::buf_count_t'(oq_pkg::buffer_depth);
            buffer_used <= '0;
        end
        else if (wr_valid && !rd_en)
        begin
            buffer_free <= buffer_free - 1'b1;
            buffer_used <= buffer_used + 1'b1;
        end
        else if (!wr_valid && rd_en)
        begin
            buffer_free <= buffer_free + 1'b1;
            buffer_used <= buffer_used - 1'b1;
        end
    end

    // single threshold, no hysteresis
    assign almost_full = (buffer_free <= oq_pkg::buf_count_t'(oq_pkg::almost_full_level));

endmodule

`default_nettype wire

/* logic/rank_sorter.sv */
`timescale 1ns/100ps
`default_nettype none

module rank_sorter
(
    input  wire logic                  axis_aclk,
    input  wire logic                  axis_resetn,

    input  wire logic                  insert,
    input  wire oq_pkg::sorter_entry_t insert_entry,
    input  wire logic                  pop,

    output oq_pkg::sorter_entry_t      top_entry,
    output logic                       empty,
    output logic                       full
);

    // slot 0 holds the lowest rank
    oq_pkg::sorter_entry_t           slot_entry [oq_pkg::sorter_depth];
    logic [oq_pkg::sorter_depth-1:0] slot_valid;

    // array after an optional pop
    oq_pkg::sorter_entry_t           pop_entry  [oq_pkg::sorter_depth];
    logic [oq_pkg::sorter_depth-1:0] pop_valid;

    // slot stays ahead of the new entry
    logic [oq_pkg::sorter_depth-1:0] keep;

    oq_pkg::sorter_entry_t           next_entry [oq_pkg::sorter_depth];
    logic [oq_pkg::sorter_depth-1:0] next_valid;

    ////////////////////
    // pop shift
    ////////////////////

    always_comb
    begin
        for (int i = 0; i < oq_pkg::sorter_depth - 1; i++)
        begin
            pop_entry[i] = pop ? slot_entry[i+1] : slot_entry[i];
            pop_valid[i] = pop ? slot_valid[i+1] : slot_valid[i];
        end
        // last slot empties on pop
        pop_entry[oq_pkg::sorter_depth-1] = slot_entry[oq_pkg::sorter_depth-1];
        pop_valid[oq_pkg::sorter_depth-1] = slot_valid[oq_pkg::sorter_depth-1] && !pop;
    end

    ////////////////////
    // insert
    ////////////////////

    always_comb
    begin
        // equal rank stays ahead, keeps arrival order
        for (int i = 0; i < oq_pkg::sorter_depth; i++)
        begin
            keep[i] = pop_valid[i] && (pop_entry[i].rank <= insert_entry.rank);
        end

        next_entry = pop_entry;
        next_valid = pop_valid;
        if (insert)
        begin
            if (!keep[0])
            begin
                next_entry[0] = insert_entry;
                next_valid[0] = 1'b1;
            end
            // first non-kept slot takes the entry, the rest move back one
            for (int i = 1; i < oq_pkg::sorter_depth; i++)
            begin
                if (!keep[i])
                begin
                    next_entry[i] = keep[i-1] ? insert_entry : pop_entry[i-1];
                    next_valid[i] = keep[i-1] ? 1'b1 : pop_valid[i-1];
                end
            end
        end
    end

    // control state
    always_ff @(posedge axis_aclk)
    begin
        if (!axis_resetn)
        begin
            slot_valid <= '0;
        end
        else
        begin
            slot_valid <= next_valid;
        end
    end

    // entries
    always_ff @(posedge axis_aclk)
    begin
        slot_entry <= next_entry;
    end

    assign top_entry = slot_entry[0];
    assign empty     = !slot_valid[0];
    assign full      = slot_valid[oq_pkg::sorter_depth-1];

endmodule

`default_nettype wire

/* logic/dequeue_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module dequeue_ctrl
(
    input  wire logic                        axis_aclk,
    input  wire logic                        axis_resetn,

    // sorter side
    input  wire oq_pkg::sorter_entry_t       top_entry,
    input  wire logic                        sorter_empty,
    output logic                             pop,

    // buffer read port
    output logic                             rd_en,
    output oq_pkg::buf_addr_t                rd_addr,
    input  wire oq_stream_pkg::stream_beat_t rd_beat,
    input  wire oq_pkg::buf_addr_t           rd_next,

    // egress stream
    input  wire logic                        tx_ready,
    output oq_stream_pkg::stream_beat_t      tx_beat,
    output logic                             tx_valid
);

    typedef enum logic [1:0] {
        st_idle,
        st_fetch,
        st_send
    } deq_state_t;

    deq_state_t state;
    deq_state_t state_next;
    logic       transfer;

    assign transfer = tx_valid && tx_ready;

    ////////////////////
    // next state
    ////////////////////

    always_comb
    begin
        state_next = state;
        pop        = 1'b0;
        rd_en      = 1'b0;
        // follow the chain unless starting a packet
        rd_addr    = rd_next;
        case (state)
            st_idle:
            begin
                // pop lowest rank, read its first word
                if (!sorter_empty && !tx_valid)
                begin
                    pop        = 1'b1;
                    rd_en      = 1'b1;
                    rd_addr    = top_entry.sop_addr;
                    state_next = st_fetch;
                end
            end
            st_fetch:
            begin
                // read word lands this cycle
                state_next = st_send;
            end
            st_send:
            begin
                if (transfer)
                begin
                    if (tx_beat.last)
                    begin
                        state_next = st_idle;
                    end
                    else
                    begin
                        rd_en      = 1'b1;
                        state_next = st_fetch;
                    end
                end
            end
            default:
            begin
                state_next = st_idle;
            end
        endcase
    end

    always_ff @(posedge axis_aclk)
    begin
        if (!axis_resetn)
        begin
            state    <= st_idle;
            tx_valid <= 1'b0;
        end
        else
        begin
            state <= state_next;
            if (state == st_fetch)
            begin
                tx_valid <= 1'b1;
            end
            else if (transfer)
            begin
                tx_valid <= 1'b0;
            end
        end
    end

    // beat held until transferred
    always_ff @(posedge axis_aclk)
    begin
        if (state == st_fetch)
        begin
            tx_beat <= rd_beat;
        end
    end

endmodule

`default_nettype wire

/* logic/output_queue.sv */
`timescale 1ns/100ps
`default_nettype none

module output_queue
(
    input  wire logic                        axis_aclk,
    input  wire logic                        axis_resetn,

    // ingress, no back-pressure
    input  wire logic                        rx_valid,
    input  wire oq_stream_pkg::stream_beat_t rx_beat,
    input  wire oq_pkg::rank_t               rx_rank,

    // egress
    input  wire logic                        tx_ready,
    output logic                             tx_valid,
    output oq_stream_pkg::stream_beat_t      tx_beat,

    // status
    output oq_pkg::buf_count_t               buffer_free,
    output oq_pkg::buf_count_t               buffer_used,
    output logic                             buffer_almost_full,
    output logic                             sorter_full
);

    ////////////////////
    // internal nets
    ////////////////////

    // buffer to sorter
    oq_pkg::sorter_entry_t       pkt_entry;
    logic                        pkt_done;

    // sorter to controller
    oq_pkg::sorter_entry_t       top_entry;
    logic                        sorter_empty;
    logic                        pop;

    // controller read port
    logic                        rd_en;
    oq_pkg::buf_addr_t           rd_addr;
    oq_stream_pkg::stream_beat_t rd_beat;
    oq_pkg::buf_addr_t           rd_next;

    pkt_buffer pkt_buffer_i
    (
        .axis_aclk   (axis_aclk),
        .axis_resetn (axis_resetn),
        .wr_valid    (rx_valid),
        .wr_beat     (rx_beat),
        .wr_rank     (rx_rank),
        .rd_en       (rd_en),
        .rd_addr     (rd_addr),
        .rd_beat     (rd_beat),
        .rd_next     (rd_next),
        .pkt_entry   (pkt_entry),
        .pkt_done    (pkt_done),
        .buffer_free (buffer_free),
        .buffer_used (buffer_used),
        .almost_full (buffer_almost_full)
    );

    // eligible packets, lowest rank on top
    rank_sorter rank_sorter_i
    (
        .axis_aclk    (axis_aclk),
        .axis_resetn  (axis_resetn),
        .insert       (pkt_done),
        .insert_entry (pkt_entry),
        .pop          (pop),
        .top_entry    (top_entry),
        .empty        (sorter_empty),
        .full         (sorter_full)
    );

    dequeue_ctrl dequeue_ctrl_i
    (
        .axis_aclk    (axis_aclk),
        .axis_resetn  (axis_resetn),
        .top_entry    (top_entry),
        .sorter_empty (sorter_empty),
        .pop          (pop),
        .rd_en        (rd_en),
        .rd_addr      (rd_addr),
        .rd_beat      (rd_beat),
        .rd_next      (rd_next),
        .tx_ready     (tx_ready),
        .tx_beat      (tx_beat),
        .tx_valid     (tx_valid)
    );

endmodule

`default_nettype wire

/* bench/oq_ref_model.svh */
`ifndef OQ_REF_MODEL_SVH
`define OQ_REF_MODEL_SVH

////////////////////
// reference queue
////////////////////

// one packet as seen on ingress
typedef struct packed {
    oq_pkg::rank_t rank;
    int            seq;
    // index of first beat in beat_pool
    int            first;
    int            len;
    // edge that wrote the last beat
    int            done_cycle;
} ref_pkt_t;

// completed packets, not yet started on egress
ref_pkt_t                    ref_pending [$];
// every beat ever written, in arrival order
oq_stream_pkg::stream_beat_t beat_pool [$];

// packet under assembly on ingress
ref_pkt_t                    rx_pkt;
logic                        rx_open = 1'b0;
int                          rx_seq  = 0;

// ingress monitor, one call per written beat
function automatic void record_rx_beat(input oq_stream_pkg::stream_beat_t beat,
                                       input oq_pkg::rank_t rank, input int cyc);
    // first beat opens a packet, rank only taken here
    if (!rx_open)
    begin
        rx_pkt.rank  = rank;
        rx_pkt.seq   = rx_seq;
        rx_pkt.first = beat_pool.size();
        rx_pkt.len   = 0;
        rx_seq++;
        rx_open      = 1'b1;
    end
    beat_pool.push_back(beat);
    rx_pkt.len++;
    if (beat.last)
    begin
        rx_pkt.done_cycle = cyc;
        ref_pending.push_back(rx_pkt);
        rx_open           = 1'b0;
    end
endfunction

// lowest rank among packets stored by the cutoff edge, oldest first on a tie
// len of zero means nothing was eligible
function automatic ref_pkt_t expected_next(input int cutoff);
    ref_pkt_t best;
    int       best_idx;
    best     = '0;
    best_idx = -1;
    foreach (ref_pending[i])
    begin
        if (ref_pending[i].done_cycle <= cutoff)
        begin
            if (best_idx < 0 || ref_pending[i].rank < best.rank ||
                (ref_pending[i].rank == best.rank && ref_pending[i].seq < best.seq))
            begin
                best     = ref_pending[i];
                best_idx = i;
            end
        end
    end
    if (best_idx >= 0)
    begin
        ref_pending.delete(best_idx);
    end
    return best;
endfunction

////////////////////
// packet generator
////////////////////

// drive one packet, then two idle cycles so the flags catch up
task automatic send_packet(input oq_pkg::rank_t rank, input int len);
    oq_stream_pkg::stream_beat_t beat;
    beats_generated += len;
    for (int i = 0; i < len; i++)
    begin
        beat.data = {$urandom, $urandom};
        beat.last = (i == len - 1);
        // partial keep only on the closing beat
        beat.keep = beat.last ? oq_stream_pkg::beat_keep_t'(8'hff >> $urandom_range(0, 7))
                              : 8'hff;
        @(posedge axis_aclk);
        rx_valid <= 1'b1;
        rx_beat  <= beat;
        // rank is junk after the first beat
        rx_rank  <= (i == 0) ? rank : oq_pkg::rank_t'($urandom);
    end
    @(posedge axis_aclk);
    rx_valid <= 1'b0;
    repeat (2) @(posedge axis_aclk);
endtask

task automatic send_random_packet(input int max_rank);
    oq_pkg::rank_t rank;
    int            len;
    rank = oq_pkg::rank_t'($urandom_range(0, max_rank));
    len  = $urandom_range(1, 8);
    send_packet(rank, len);
endtask

// upstream respects both full flags
task automatic wait_for_room();
    while (buffer_almost_full || sorter_full)
    begin
        @(posedge axis_aclk);
    end
endtask

`endif

/* bench/output_queue_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module output_queue_tb;

    logic                        axis_aclk;
    logic                        axis_resetn;
    logic                        rx_valid;
    oq_stream_pkg::stream_beat_t rx_beat;
    oq_pkg::rank_t               rx_rank;
    logic                        tx_ready;
    logic                        tx_valid;
    oq_stream_pkg::stream_beat_t tx_beat;
    oq_pkg::buf_count_t          buffer_free;
    oq_pkg::buf_count_t          buffer_used;
    logic                        buffer_almost_full;
    logic                        sorter_full;

    int value_errors    = 0;
    int other_errors    = 0;
    int beats_generated = 0;
    int cycle_count     = 0;

    // tx_ready source: 0 low, 1 high, 2 random
    logic [1:0] ready_mode;

    `include "oq_ref_model.svh"

    // egress packet being compared
    logic     out_active = 1'b0;
    ref_pkt_t out_pkt;
    int       out_pos;

    output_queue output_queue_i
    (
        .axis_aclk          (axis_aclk),
        .axis_resetn        (axis_resetn),
        .rx_valid           (rx_valid),
        .rx_beat            (rx_beat),
        .rx_rank            (rx_rank),
        .tx_ready           (tx_ready),
        .tx_valid           (tx_valid),
        .tx_beat            (tx_beat),
        .buffer_free        (buffer_free),
        .buffer_used        (buffer_used),
        .buffer_almost_full (buffer_almost_full),
        .sorter_full        (sorter_full)
    );

    // 4 ns clock
    initial
    begin
        axis_aclk = 1'b0;
        forever #2 axis_aclk = ~axis_aclk;
    end

    always @(posedge axis_aclk)
    begin
        case (ready_mode)
            2'd0:    tx_ready <= 1'b0;
            2'd1:    tx_ready <= 1'b1;
            default: tx_ready <= 1'($urandom_range(0, 1));
        endcase
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        assert (got === expected)
        else
        begin
            value_errors++;
            $display("Fail %s: got %h, expected %h", name, got, expected);
        end
    endtask

    task automatic wait_drained(input int limit);
        int waited;
        waited = 0;
        while ((ref_pending.size() != 0 || out_active) && waited < limit)
        begin
            @(posedge axis_aclk);
            waited++;
        end
        assert (waited < limit)
        else
        begin
            other_errors++;
            $display("queue did not drain within %0d cycles", limit);
        end
        // counters settle after the last read
        repeat (4) @(posedge axis_aclk);
    endtask

    ////////////////////
    // compare process
    ////////////////////

    always @(posedge axis_aclk)
    begin : compare_proc
        oq_stream_pkg::stream_beat_t exp_beat;
        oq_stream_pkg::stream_beat_t held_beat;
        logic                        stalled;
        if (!axis_resetn)
        begin
            stalled    = 1'b0;
            out_active = 1'b0;
        end
        else
        begin
            if (rx_valid)
            begin
                record_rx_beat(rx_beat, rx_rank, cycle_count);
            end
            // beat frozen while stalled
            if (stalled)
            begin
                assert (tx_valid)
                else
                begin
                    other_errors++;
                    $display("tx_valid dropped while tx_ready was low");
                end
                assert (tx_beat === held_beat)
                else
                begin
                    value_errors++;
                    $display("Fail tx_beat: got %h, expected %h", tx_beat, held_beat);
                end
            end
            // new packet, popped two edges before tx_valid rose
            if (tx_valid && !out_active)
            begin
                out_pkt = expected_next(cycle_count - 4);
                out_pos = 0;
                out_active = (out_pkt.len != 0);
                assert (out_active)
                else
                begin
                    other_errors++;
                    $display("packet started on egress with none eligible");
                end
            end
            if (tx_valid && tx_ready && out_active)
            begin
                exp_beat = beat_pool[out_pkt.first + out_pos];
                assert (tx_beat.data == exp_beat.data)
                else
                begin
                    value_errors++;
                    $display("Fail tx_beat.data: got %h, expected %h",
                             tx_beat.data, exp_beat.data);
                end
                assert (tx_beat.keep == exp_beat.keep)
                else
                begin
                    value_errors++;
                    $display("Fail tx_beat.keep: got %h, expected %h",
                             tx_beat.keep, exp_beat.keep);
                end
                assert (tx_beat.last == exp_beat.last)
                else
                begin
                    value_errors++;
                    $display("Fail tx_beat.last: got %h, expected %h",
                             tx_beat.last, exp_beat.last);
                end
                out_pos++;
                if (out_pos == out_pkt.len)
                begin
                    out_active = 1'b0;
                end
            end
            stalled   = tx_valid && !tx_ready;
            held_beat = tx_beat;
        end
        cycle_count++;
    end

    ////////////////////
    // stimulus
    ////////////////////

    initial
    begin : main_seq
        void'($urandom(62));
        axis_resetn = 1'b0;
        rx_valid    = 1'b0;
        rx_beat     = '0;
        rx_rank     = '0;
        tx_ready    = 1'b0;
        ready_mode  = 2'd0;
        repeat (16) @(posedge axis_aclk);
        axis_resetn <= 1'b1;
        @(posedge axis_aclk);

        // state straight out of reset
        check_value("tx_valid", tx_valid, 0);
        check_value("buffer_free", buffer_free, 256);
        check_value("buffer_used", buffer_used, 0);
        check_value("buffer_almost_full", buffer_almost_full, 0);
        check_value("sorter_full", sorter_full, 0);

        // single 5-beat packet
        ready_mode <= 2'd1;
        send_packet(16'd7, 5);
        wait_drained(2000);

        // rank order, ties from a narrow range
        ready_mode <= 2'd0;
        repeat (8) send_random_packet(3);
        repeat (8) @(posedge axis_aclk);
        ready_mode <= 2'd1;
        wait_drained(2000);

        // random back-pressure while packets keep arriving
        ready_mode <= 2'd2;
        repeat (40)
        begin
            wait_for_room();
            send_random_packet(15);
        end
        ready_mode <= 2'd1;
        wait_drained(4000);

        // occupancy, the controller already holds one fetched beat
        ready_mode <= 2'd0;
        repeat (16) send_packet(oq_pkg::rank_t'($urandom_range(0, 15)), 14);
        repeat (8) @(posedge axis_aclk);
        check_value("buffer_used", buffer_used, 223);
        check_value("buffer_free", buffer_free, 33);
        check_value("buffer_almost_full", buffer_almost_full, 0);
        check_value("sorter_full", sorter_full, 0);
        send_packet(oq_pkg::rank_t'($urandom_range(0, 15)), 1);
        repeat (8) @(posedge axis_aclk);
        check_value("buffer_used", buffer_used, 224);
        check_value("buffer_free", buffer_free, 32);
        check_value("buffer_almost_full", buffer_almost_full, 1);
        check_value("sorter_full", sorter_full, 1);
        ready_mode <= 2'd1;
        wait_drained(4000);
        check_value("buffer_free", buffer_free, 256);
        check_value("buffer_used", buffer_used, 0);
        check_value("sorter_full", sorter_full, 0);

        // second round on recycled addresses
        ready_mode <= 2'd2;
        repeat (20)
        begin
            wait_for_room();
            send_random_packet(7);
        end
        ready_mode <= 2'd1;
        wait_drained(4000);
        check_value("buffer_free", buffer_free, 256);
        check_value("buffer_used", buffer_used, 0);

        $display("errors: %0d value mismatches, %0d other failures",
                 value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0)
        begin
            $display("All tests passed!");
        end
        else
        begin
            $display("Test failures found");
        end
        $finish;
    end

    // limit grows with every generated beat
    initial
    begin : watchdog
        int wd_cycles;
        wd_cycles = 0;
        while (wd_cycles <= 2000 + 40 * beats_generated)
        begin
            @(posedge axis_aclk);
            wd_cycles++;
        end
        $display("watchdog expired after %0d cycles", wd_cycles);
        $display("errors: %0d value mismatches, %0d other failures",
                 value_errors, other_errors);
        $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
+incdir+bench
logic/oq_pkg.sv
logic/oq_stream_pkg.sv
logic/pkt_buffer.sv
logic/rank_sorter.sv
logic/dequeue_ctrl.sv
logic/output_queue.sv
bench/output_queue_tb.sv
